// File: cache_bank.f
cache_bank_pkg.sv
bank_fifo.sv
miss_resrv.sv
tag_data_store.sv
bank_pipe.sv
cache_bank.sv
cache_bank_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the cache bank testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cache_bank_tb \
    -f cache_bank.f -o cache_bank_sim > build.log 2>&1 \
    && ./obj_dir/cache_bank_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "Result: failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "Result: no verdict in sim.log"; exit 1; }
echo "Result: passed"

// File: cache_bank_stim.txt
# test  byte_addr  tag  expected_word  backpressure   (all hex)
# expected word is the word-aligned byte address XOR 5a5a5a5a
# test 1: cold miss on an empty bank
1 00000100 01 5a5a5b5a 0
# test 2: other words of the same line hit
2 00000104 02 5a5a5b5e 0
2 00000108 03 5a5a5b52 0
2 0000010c 04 5a5a5b56 0
# test 3: outstanding misses to several lines, some to one line
3 00000210 10 5a5a584a 0
3 00000324 11 5a5a597e 0
3 00000214 12 5a5a584e 0
3 0000043c 13 5a5a5e66 0
3 00000328 14 5a5a5972 0
3 00000218 15 5a5a5842 0
# test 4: two lines at index 0, read alternately
4 00002000 20 5a5a7a5a 0
4 00003004 21 5a5a6a5e 0
4 00002008 22 5a5a7a52 0
4 0000300c 23 5a5a6a56 0
# test 5: hits and misses with random ready on both outputs
5 00000550 30 5a5a5f0a 1
5 0000021c 31 5a5a5846 1
5 00000664 32 5a5a5c3e 1
5 00000554 33 5a5a5f0e 1
5 000abcd8 34 5a50e682 1
5 00003008 35 5a5a6a52 1
5 00000874 36 5a5a522e 1
5 0000032c 37 5a5a5976 1
# test 6: eviction and refill under random ready
6 00001558 40 5a5a4f02 1
6 00000558 41 5a5a5f02 1
6 00000668 42 5a5a5c32 1
6 000abcd0 43 5a50e68a 1
6 0000087c 44 5a5a5226 1
6 00000990 45 5a5a53ca 1

// File: cache_bank_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cache_bank_tb;

    import cache_bank_pkg::*;

    localparam int          NUM_LINES      = 16;
    localparam int          MAX_REQS       = 64;
    localparam int          CYCLES_PER_REQ = 200;
    localparam logic [31:0] SEED           = 32'hfef82970;

    logic        clk;
    logic        rst;
    logic        core_req_valid;
    core_req_t   core_req;
    logic        core_req_ready;
    logic        core_rsp_valid;
    core_rsp_t   core_rsp;
    logic        core_rsp_ready;
    logic        dram_fill_req_valid;
    line_addr_t  dram_fill_req_addr;
    logic        dram_fill_req_ready;
    logic        dram_fill_rsp_valid;
    fill_rsp_t   dram_fill_rsp;
    logic        dram_fill_rsp_ready;

    int          num_reqs;
    logic [31:0] st_test [MAX_REQS];
    addr_t       st_addr [MAX_REQS];
    core_tag_t   st_tag  [MAX_REQS];
    word_t       st_word [MAX_REQS];
    logic        st_bp   [MAX_REQS];

    // Scoreboard indexed by tag
    logic        pending   [256];
    word_t       exp_word  [256];
    line_addr_t  pend_line [256];

    // Which line each index should hold, now and at the start of a test
    logic        model_valid [NUM_LINES];
    line_addr_t  model_line  [NUM_LINES];
    logic        start_valid [NUM_LINES];
    line_addr_t  start_line  [NUM_LINES];

    line_addr_t  dram_addr_q [$];
    int          dram_due_q  [$];
    int          fill_reqs_seen;
    logic        dram_busy;

    int          cycles;
    int          cycle_limit;
    int          err_count;
    int          tests_passed;
    int          tests_failed;
    logic        bp_on;

    cache_bank #(
        .NUM_LINES           (NUM_LINES)
    ) dut0 (
        .clk                 (clk),
        .rst                 (rst),
        .core_req_valid      (core_req_valid),
        .core_req            (core_req),
        .core_req_ready      (core_req_ready),
        .core_rsp_valid      (core_rsp_valid),
        .core_rsp            (core_rsp),
        .core_rsp_ready      (core_rsp_ready),
        .dram_fill_req_valid (dram_fill_req_valid),
        .dram_fill_req_addr  (dram_fill_req_addr),
        .dram_fill_req_ready (dram_fill_req_ready),
        .dram_fill_rsp_valid (dram_fill_rsp_valid),
        .dram_fill_rsp       (dram_fill_rsp),
        .dram_fill_rsp_ready (dram_fill_rsp_ready)
    );

    always #4 clk = ~clk;

    function automatic int line_index(input line_addr_t la);
        return int'(la % NUM_LINES);
    endfunction

    // Each DRAM word is its byte address XOR 5a5a5a5a
    function automatic line_t dram_line(input line_addr_t la);
        line_t ln;
        addr_t a;
        for (int w = 0; w < LINE_WORDS; w++) begin
            a = {la, 4'b0000} + addr_t'(w * WORD_BYTES);
            ln[w*32 +: 32] = a ^ 32'h5a5a5a5a;
        end
        return ln;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int t = 0; t < 256; t++) begin
            if (pending[t]) begin
                n++;
            end
        end
        return n;
    endfunction

    // An outstanding read to another line at the same index
    function automatic logic index_busy(input line_addr_t la);
        for (int t = 0; t < 256; t++) begin
            if (pending[t] && line_index(pend_line[t]) == line_index(la)
                    && pend_line[t] != la) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // An outstanding read that waits on this very line
    function automatic logic line_pending(input line_addr_t la);
        for (int t = 0; t < 256; t++) begin
            if (pending[t] && pend_line[t] == la) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic read_stimulus();
        int            fd;
        int            got;
        logic [1023:0] text;
        logic [31:0]   f_test;
        logic [31:0]   f_addr;
        logic [31:0]   f_tag;
        logic [31:0]   f_word;
        logic [31:0]   f_bp;
        num_reqs = 0;
        fd = $fopen("cache_bank_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_reqs < MAX_REQS) begin
                text = '0;
                got = $fgets(text, fd);
                if (got > 0 && $sscanf(text, "%h %h %h %h %h",
                        f_test, f_addr, f_tag, f_word, f_bp) == 5) begin
                    st_test[num_reqs] = f_test;
                    st_addr[num_reqs] = f_addr;
                    st_tag[num_reqs]  = f_tag[7:0];
                    st_word[num_reqs] = f_word;
                    st_bp[num_reqs]   = f_bp[0];
                    num_reqs++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_req(input int i);
        line_addr_t la;
        la = st_addr[i][31:4];
        core_req_valid <= 1'b0;
        // Reads that would evict each other's line go one at a time
        while (index_busy(la)) begin
            @(posedge clk);
        end
        pending[st_tag[i]]   = 1'b1;
        exp_word[st_tag[i]]  = st_word[i];
        pend_line[st_tag[i]] = la;
        core_req_valid <= 1'b1;
        core_req.addr  <= st_addr[i];
        core_req.tag   <= st_tag[i];
        do begin
            @(posedge clk);
        end while (!core_req_ready);
    endtask

    task automatic run_tests();
        int         i;
        int         cur;
        int         n;
        int         lo;
        int         hi;
        int         idx;
        int         fills;
        int         fills_before;
        int         errs_before;
        logic       run_miss;
        logic       start_miss;
        line_addr_t la;
        i = 0;
        while (i < num_reqs) begin
            cur          = st_test[i];
            bp_on        = st_bp[i];
            fills_before = fill_reqs_seen;
            errs_before  = err_count;
            n  = 0;
            lo = 0;
            hi = 0;
            for (int k = 0; k < NUM_LINES; k++) begin
                start_valid[k] = model_valid[k];
                start_line[k]  = model_line[k];
            end
            while (i < num_reqs && st_test[i] == cur) begin
                la         = st_addr[i][31:4];
                idx        = line_index(la);
                run_miss   = !model_valid[idx] || model_line[idx] != la;
                start_miss = !start_valid[idx] || start_line[idx] != la;
                // Overlapping misses to one line may each raise a fill
                if (run_miss) begin
                    lo++;
                end
                if (run_miss || start_miss) begin
                    hi++;
                end
                model_valid[idx] = 1'b1;
                model_line[idx]  = la;
                send_req(i);
                i++;
                n++;
            end
            core_req_valid <= 1'b0;
            while (pending_count() != 0 || dram_addr_q.size() != 0 || dram_fill_rsp_valid) begin
                @(posedge clk);
            end
            repeat (8) @(posedge clk);
            fills = fill_reqs_seen - fills_before;
            if (fills < lo || fills > hi) begin
                err_count++;
                $display("ERR %0t: test %0d saw %0d fill requests, expected %0d to %0d",
                         $time, cur, fills, lo, hi);
            end
            if (err_count == errs_before) begin
                tests_passed++;
            end else begin
                tests_failed++;
            end
            $display("Test %0d %s: %0d reads, %0d fill requests", cur,
                     (err_count == errs_before) ? "passed" : "failed", n, fills);
        end
        bp_on = 1'b0;
    endtask

    always @(posedge clk) begin
        if (!rst && core_rsp_valid && core_rsp_ready) begin
            if (!pending[core_rsp.tag]) begin
                err_count++;
                $display("Response at %0t carries tag %h, which has no read outstanding",
                         $time, core_rsp.tag);
            end else begin
                if (core_rsp.data != exp_word[core_rsp.tag]) begin
                    err_count++;
                    $display("ERR %0t: tag %h returned %h, expected %h", $time,
                             core_rsp.tag, core_rsp.data, exp_word[core_rsp.tag]);
                end
                pending[core_rsp.tag] = 1'b0;
            end
        end
    end

    // Random ready toggling while a back-pressure test runs
    always @(posedge clk) begin
        if (rst || !bp_on) begin
            core_rsp_ready      <= 1'b1;
            dram_fill_req_ready <= 1'b1;
        end else begin
            core_rsp_ready      <= ($urandom % 2) != 0;
            dram_fill_req_ready <= ($urandom % 2) != 0;
        end
    end

    // DRAM model answers in request order after 1 to 8 cycles
    always @(posedge clk) begin
        if (rst) begin
            dram_fill_rsp_valid <= 1'b0;
        end else begin
            if (dram_fill_req_valid && dram_fill_req_ready) begin
                if (!line_pending(dram_fill_req_addr)) begin
                    err_count++;
                    $display("ERR %0t: fill request for line %h with no read outstanding",
                             $time, dram_fill_req_addr);
                end
                dram_addr_q.push_back(dram_fill_req_addr);
                dram_due_q.push_back(cycles + 1 + int'($urandom % 8));
                fill_reqs_seen++;
            end
            dram_busy = dram_fill_rsp_valid && !dram_fill_rsp_ready;
            if (!dram_busy) begin
                if (dram_addr_q.size() > 0 && cycles >= dram_due_q[0]) begin
                    dram_fill_rsp_valid <= 1'b1;
                    dram_fill_rsp.addr  <= dram_addr_q[0];
                    dram_fill_rsp.data  <= dram_line(dram_addr_q[0]);
                    void'(dram_addr_q.pop_front());
                    void'(dram_due_q.pop_front());
                end else begin
                    dram_fill_rsp_valid <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d responses never arrived",
                     cycles, pending_count());
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        clk                 = 1'b0;
        rst                 = 1'b1;
        core_req_valid      = 1'b0;
        core_req            = '0;
        core_rsp_ready      = 1'b1;
        dram_fill_req_ready = 1'b1;
        dram_fill_rsp_valid = 1'b0;
        dram_fill_rsp       = '0;
        bp_on               = 1'b0;
        cycles              = 0;
        cycle_limit         = 0;
        err_count           = 0;
        tests_passed        = 0;
        tests_failed        = 0;
        fill_reqs_seen      = 0;
        for (int t = 0; t < 256; t++) begin
            pending[t] = 1'b0;
        end
        for (int k = 0; k < NUM_LINES; k++) begin
            model_valid[k] = 1'b0;
            model_line[k]  = '0;
        end
        void'($urandom(SEED));
        read_stimulus();
        if (num_reqs == 0) begin
            $display("No stimulus lines could be read from cache_bank_stim.txt");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            cycle_limit = CYCLES_PER_REQ * num_reqs;
            repeat (5) @(posedge clk);
            rst <= 1'b0;
            @(posedge clk);
            run_tests();
            $display("Tests %0d, passed %0d, failed %0d, errors %0d",
                     tests_passed + tests_failed, tests_passed, tests_failed, err_count);
            if (err_count == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: cache_bank.sv
`timescale 1ns/100ps
`default_nettype none

module cache_bank #(
    parameter int NUM_LINES   = 16,
    parameter int REQQ_DEPTH  = 4,
    parameter int FILLQ_DEPTH = 4,
    parameter int RSPQ_DEPTH  = 4,
    parameter int MRVQ_DEPTH  = 4
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             core_req_valid,
    input  wire cache_bank_pkg::core_req_t  core_req,
    output logic                            core_req_ready,
    output logic                            core_rsp_valid,
    output cache_bank_pkg::core_rsp_t       core_rsp,
    input  wire                             core_rsp_ready,
    output logic                            dram_fill_req_valid,
    output cache_bank_pkg::line_addr_t      dram_fill_req_addr,
    input  wire                             dram_fill_req_ready,
    input  wire                             dram_fill_rsp_valid,
    input  wire cache_bank_pkg::fill_rsp_t  dram_fill_rsp,
    output logic                            dram_fill_rsp_ready
);

    import cache_bank_pkg::*;

    logic       reqq_valid;
    core_req_t  reqq_data;
    logic       reqq_ready;

    logic       fillq_valid;
    fill_rsp_t  fillq_data;
    logic       fillq_ready;

    logic       rspq_valid;
    core_rsp_t  rspq_data;
    logic       rspq_ready;

    bank_fifo #(
        .DATA_T    (core_req_t),
        .DEPTH     (REQQ_DEPTH)
    ) req_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (core_req_valid),
        .in_data   (core_req),
        .in_ready  (core_req_ready),
        .out_valid (reqq_valid),
        .out_data  (reqq_data),
        .out_ready (reqq_ready)
    );

    bank_fifo #(
        .DATA_T    (fill_rsp_t),
        .DEPTH     (FILLQ_DEPTH)
    ) fill_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (dram_fill_rsp_valid),
        .in_data   (dram_fill_rsp),
        .in_ready  (dram_fill_rsp_ready),
        .out_valid (fillq_valid),
        .out_data  (fillq_data),
        .out_ready (fillq_ready)
    );

    bank_pipe #(
        .NUM_LINES           (NUM_LINES),
        .MRVQ_DEPTH          (MRVQ_DEPTH)
    ) pipe (
        .clk                 (clk),
        .rst                 (rst),
        .req_valid           (reqq_valid),
        .req                 (reqq_data),
        .req_ready           (reqq_ready),
        .fill_valid          (fillq_valid),
        .fill                (fillq_data),
        .fill_ready          (fillq_ready),
        .rsp_valid           (rspq_valid),
        .rsp                 (rspq_data),
        .rsp_ready           (rspq_ready),
        .dram_fill_req_valid (dram_fill_req_valid),
        .dram_fill_req_addr  (dram_fill_req_addr),
        .dram_fill_req_ready (dram_fill_req_ready)
    );

    // Hits drain to the core through here
    bank_fifo #(
        .DATA_T    (core_rsp_t),
        .DEPTH     (RSPQ_DEPTH)
    ) rsp_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (rspq_valid),
        .in_data   (rspq_data),
        .in_ready  (rspq_ready),
        .out_valid (core_rsp_valid),
        .out_data  (core_rsp),
        .out_ready (core_rsp_ready)
    );

endmodule

`default_nettype wire

// File: bank_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module bank_pipe #(
    parameter int NUM_LINES  = 16,
    parameter int MRVQ_DEPTH = 4
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             req_valid,
    input  wire cache_bank_pkg::core_req_t  req,
    output logic                            req_ready,
    input  wire                             fill_valid,
    input  wire cache_bank_pkg::fill_rsp_t  fill,
    output logic                            fill_ready,
    output logic                            rsp_valid,
    output cache_bank_pkg::core_rsp_t       rsp,
    input  wire                             rsp_ready,
    output logic                            dram_fill_req_valid,
    output cache_bank_pkg::line_addr_t      dram_fill_req_addr,
    input  wire                             dram_fill_req_ready
);

    import cache_bank_pkg::*;

    pipe_item_t     sel;
    pipe_item_t     s1;
    pipe_item_t     s2;
    logic           hit_s1;
    word_t          word_s1;
    logic           hit_s2;
    word_t          word_s2;

    logic           stall;
    logic           fill_in_pipe;
    logic           miss_s2;
    logic           miss_add;
    miss_entry_t    miss_entry;
    logic           mrvq_full;
    logic           mrvq_almost_full;
    logic           replay_valid;
    miss_entry_t    replay_entry;
    logic           fill_bcast;

    // Stage 0 priority is replay, then fill, then core request
    assign fill_in_pipe = (s1.valid && s1.is_fill) || (s2.valid && s2.is_fill);
    assign fill_ready   = !replay_valid && !stall;
    assign req_ready    = !replay_valid && !fill_valid && !mrvq_almost_full
                       && !fill_in_pipe && !stall;

    always_comb begin
        sel = '0;
        if (replay_valid && !stall) begin
            sel.valid = 1'b1;
            sel.addr  = replay_entry.addr;
            sel.wsel  = replay_entry.wsel;
            sel.tag   = replay_entry.tag;
        end else if (fill_valid && fill_ready) begin
            sel.valid   = 1'b1;
            sel.is_fill = 1'b1;
            sel.addr    = fill.addr;
            sel.data    = fill.data;
        end else if (req_valid && req_ready) begin
            sel.valid = 1'b1;
            sel.addr  = req.addr[31:LINE_OFFSET_BITS];
            sel.wsel  = req.addr[LINE_OFFSET_BITS-1:WORD_OFFSET_BITS];
            sel.tag   = req.tag;
        end
    end

    tag_data_store #(
        .NUM_LINES   (NUM_LINES)
    ) store (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (s1.addr),
        .lookup_wsel (s1.wsel),
        .hit         (hit_s1),
        .read_word   (word_s1),
        .fill_write  (s1.valid && s1.is_fill),
        .fill_data   (s1.data)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            s1.valid   <= 1'b0;
            s1.is_fill <= 1'b0;
            s2.valid   <= 1'b0;
            s2.is_fill <= 1'b0;
        end else if (!stall) begin
            s1      <= sel;
            s2      <= s1;
            hit_s2  <= hit_s1;
            word_s2 <= word_s1;
        end
    end

    // Stage 2 routing
    assign miss_s2    = s2.valid && !s2.is_fill && !hit_s2;
    assign rsp_valid  = s2.valid && !s2.is_fill && hit_s2;
    assign rsp.tag    = s2.tag;
    assign rsp.data   = word_s2;
    assign fill_bcast = s2.valid && s2.is_fill;

    assign dram_fill_req_valid = miss_s2 && !mrvq_full;
    assign dram_fill_req_addr  = s2.addr;
    assign miss_add            = dram_fill_req_valid && dram_fill_req_ready;

    assign miss_entry.addr = s2.addr;
    assign miss_entry.wsel = s2.wsel;
    assign miss_entry.tag  = s2.tag;

    assign stall = (rsp_valid && !rsp_ready)
                || (miss_s2 && (mrvq_full || !dram_fill_req_ready));

    miss_resrv #(
        .MRVQ_DEPTH   (MRVQ_DEPTH)
    ) mrvq (
        .clk          (clk),
        .rst          (rst),
        .add          (miss_add),
        .add_entry    (miss_entry),
        .full         (mrvq_full),
        .almost_full  (mrvq_almost_full),
        .fill         (fill_bcast),
        .fill_addr    (s2.addr),
        .replay_valid (replay_valid),
        .replay_entry (replay_entry),
        .replay_ready (!stall)
    );

    // A fill request waiting on DRAM keeps its line address
    fill_req_held: assert property (@(posedge clk) disable iff (rst)
        dram_fill_req_valid && !dram_fill_req_ready
        |=> dram_fill_req_valid && $stable(dram_fill_req_addr));

endmodule

`default_nettype wire

// File: tag_data_store.sv
`timescale 1ns/100ps
`default_nettype none

module tag_data_store #(
    parameter int NUM_LINES = 16
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire cache_bank_pkg::line_addr_t lookup_addr,
    input  wire cache_bank_pkg::wsel_t      lookup_wsel,
    output logic                            hit,
    output cache_bank_pkg::word_t           read_word,
    input  wire                             fill_write,
    input  wire cache_bank_pkg::line_t      fill_data
);

    import cache_bank_pkg::*;

    // NUM_LINES must be a power of two, two or more
    localparam int INDEX_W = $clog2(NUM_LINES);
    localparam int TAG_W   = $bits(line_addr_t) - INDEX_W;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   line_tag_t;

    line_tag_t              tag_arr  [NUM_LINES];
    line_t                  data_arr [NUM_LINES];
    logic [NUM_LINES-1:0]   valid_arr;

    index_t                 idx;
    line_tag_t              lookup_tag;
    line_t                  line_rd;

    assign idx        = lookup_addr[INDEX_W-1:0];
    assign lookup_tag = lookup_addr[$bits(line_addr_t)-1:INDEX_W];
    assign line_rd    = data_arr[idx];

    // Reads see the array before this cycle's fill write
    assign hit       = valid_arr[idx] && (tag_arr[idx] == lookup_tag);
    assign read_word = line_rd[lookup_wsel*$bits(word_t) +: $bits(word_t)];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr <= '0;
        end else if (fill_write) begin
            valid_arr[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_write) begin
            tag_arr[idx]  <= lookup_tag;
            data_arr[idx] <= fill_data;
        end
    end

endmodule

`default_nettype wire

// File: miss_resrv.sv
`timescale 1ns/100ps
`default_nettype none

module miss_resrv #(
    parameter int MRVQ_DEPTH = 4
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              add,
    input  wire cache_bank_pkg::miss_entry_t add_entry,
    output logic                             full,
    output logic                             almost_full,
    input  wire                              fill,
    input  wire cache_bank_pkg::line_addr_t  fill_addr,
    output logic                             replay_valid,
    output cache_bank_pkg::miss_entry_t      replay_entry,
    input  wire                              replay_ready
);

    import cache_bank_pkg::*;

    localparam int IDX_W = (MRVQ_DEPTH > 1) ? $clog2(MRVQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(MRVQ_DEPTH + 1);

    miss_entry_t            entries [MRVQ_DEPTH];
    logic [MRVQ_DEPTH-1:0]  valid_q;
    logic [MRVQ_DEPTH-1:0]  ready_q;
    logic [IDX_W-1:0]       add_idx;
    logic [IDX_W-1:0]       replay_idx;
    logic [CNT_W-1:0]       free_cnt;

    // Lowest free slot and number of free slots
    always_comb begin
        add_idx  = '0;
        free_cnt = '0;
        for (int i = MRVQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                add_idx  = IDX_W'(i);
                free_cnt = free_cnt + 1'b1;
            end
        end
    end

    // Lowest ready entry goes back to the pipeline first
    always_comb begin
        replay_valid = 1'b0;
        replay_idx   = '0;
        for (int i = MRVQ_DEPTH - 1; i >= 0; i--) begin
            if (valid_q[i] && ready_q[i]) begin
                replay_valid = 1'b1;
                replay_idx   = IDX_W'(i);
            end
        end
    end

    assign replay_entry = entries[replay_idx];
    assign full         = &valid_q;
    // Counts this cycle's add as already taken
    assign almost_full  = (int'(free_cnt) - int'(add)) <= 1;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            ready_q <= '0;
        end else begin
            for (int i = 0; i < MRVQ_DEPTH; i++) begin
                if (fill && valid_q[i] && (entries[i].addr == fill_addr)) begin
                    ready_q[i] <= 1'b1;
                end
            end
            if (replay_valid && replay_ready) begin
                valid_q[replay_idx] <= 1'b0;
            end
            if (add) begin
                valid_q[add_idx] <= 1'b1;
                // Fill broadcast in the same cycle already covers this line
                ready_q[add_idx] <= fill && (add_entry.addr == fill_addr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (add) begin
            entries[add_idx] <= add_entry;
        end
    end

    no_add_when_full: assert property (@(posedge clk) disable iff (rst) add |-> !full);

endmodule

`default_nettype wire

// File: bank_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module bank_fifo #(
    parameter type DATA_T = logic,
    parameter int  DEPTH  = 4
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        in_valid,
    input  wire DATA_T in_data,
    output logic       in_ready,
    output logic       out_valid,
    output DATA_T      out_data,
    input  wire        out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    DATA_T             mem [DEPTH];
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    count_in_range: assert property (@(posedge clk) disable iff (rst) count <= CNT_W'(DEPTH));

    // Head entry holds still until it is taken
    out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// File: cache_bank_pkg.sv
`default_nettype none

package cache_bank_pkg;

    localparam int WORD_BYTES = 4;
    localparam int LINE_WORDS = 4;

    localparam int WORD_OFFSET_BITS = $clog2(WORD_BYTES);
    localparam int LINE_OFFSET_BITS = $clog2(WORD_BYTES * LINE_WORDS);

    typedef logic [31:0]                                    addr_t;
    typedef logic [31-LINE_OFFSET_BITS:0]                   line_addr_t;
    typedef logic [LINE_OFFSET_BITS-WORD_OFFSET_BITS-1:0]   wsel_t;
    typedef logic [WORD_BYTES*8-1:0]                        word_t;
    // Word 0 sits in the low bits
    typedef logic [LINE_WORDS*WORD_BYTES*8-1:0]             line_t;
    typedef logic [7:0]                                     core_tag_t;

    typedef struct packed {
        addr_t     addr;
        core_tag_t tag;
    } core_req_t;

    typedef struct packed {
        core_tag_t tag;
        word_t     data;
    } core_rsp_t;

    typedef struct packed {
        line_addr_t addr;
        line_t      data;
    } fill_rsp_t;

    typedef struct packed {
        line_addr_t addr;
        wsel_t      wsel;
        core_tag_t  tag;
    } miss_entry_t;

    typedef struct packed {
        logic       valid;
        logic       is_fill;
        line_addr_t addr;
        wsel_t      wsel;
        core_tag_t  tag;
        line_t      data;
    } pipe_item_t;

endpackage

`default_nettype wire
